/* rat_flags_settings.svh */
`ifndef RAT_FLAGS_SETTINGS_SVH
`define RAT_FLAGS_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and counts.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RAT_TAG_WIDTH    6
`define RAT_FUNIT_WIDTH  10
`define RAT_LANES        4
`define RAT_RET_PORTS    3
`define RAT_CODE_WIDTH   4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// special read codes and reset values.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RAT_CODE_FLAGS   14   // table entry as stored.
`define RAT_CODE_DONE    13   // table entry, seen as retired.
`define RAT_FUNIT_RESET  9

`endif

/* rat_flags_pkg.sv */
`include "rat_flags_settings.svh"

package rat_flags_pkg;

  // lane index width.
  localparam int LANE_IDX_W = $clog2(`RAT_LANES);

  // read code sources.
  localparam logic [1:0] SRC_LANE  = 2'd0;
  localparam logic [1:0] SRC_TABLE = 2'd1;
  localparam logic [1:0] SRC_DONE  = 2'd2;
  localparam logic [1:0] SRC_NONE  = 2'd3;

  // classify a latched read code.
  function automatic logic [1:0] code_source(input logic [`RAT_CODE_WIDTH-1:0] code);
    logic [1:0] src;
    if (code < `RAT_LANES)
    begin
      src = SRC_LANE;  // lane code is the lane number.
    end
    else if (code == `RAT_CODE_FLAGS)
    begin
      src = SRC_TABLE;
    end
    else if (code == `RAT_CODE_DONE)
    begin
      src = SRC_DONE;
    end
    else
    begin
      src = SRC_NONE;
    end
    return src;
  endfunction

  // highest writing lane wins, zero when none writes.
  function automatic logic [LANE_IDX_W-1:0] newest_writer(input logic [`RAT_LANES-1:0] wen);
    logic [LANE_IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < `RAT_LANES; i++)
    begin
      if (wen[i])
      begin
        idx = LANE_IDX_W'(i);
      end
    end
    return idx;
  endfunction

endpackage

/* flags_entry.sv */
`timescale 1ns/10ps
`include "rat_flags_settings.svh"

module flags_entry
  import rat_flags_pkg::*;
(
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              cur_thread,
  input  logic [`RAT_LANES-1:0]                             new_wen,
  input  logic [`RAT_LANES-1:0][`RAT_TAG_WIDTH-1:0]         new_tag,
  input  logic [`RAT_LANES-1:0][`RAT_FUNIT_WIDTH-1:0]       new_funit,
  input  logic [`RAT_RET_PORTS-1:0]                         ret_wen,
  input  logic [`RAT_RET_PORTS-1:0][`RAT_TAG_WIDTH-1:0]     ret_tag,
  input  logic                                              ret_thread,
  input  logic                                              retire_all,
  output logic [`RAT_TAG_WIDTH-1:0]                         entry_tag,
  output logic [`RAT_FUNIT_WIDTH-1:0]                       entry_funit,
  output logic                                              entry_retired
);

  localparam int THREADS = 2;
  localparam logic [`RAT_FUNIT_WIDTH-1:0] FUNIT_RESET = `RAT_FUNIT_RESET;

  // per-thread state.
  logic [`RAT_TAG_WIDTH-1:0]   tag_q     [THREADS];
  logic [`RAT_FUNIT_WIDTH-1:0] funit_q   [THREADS];
  logic                        retired_q [THREADS];

  logic                        any_new;
  logic [LANE_IDX_W-1:0]       wr_lane;
  logic [`RAT_TAG_WIDTH-1:0]   merged_tag;
  logic [`RAT_FUNIT_WIDTH-1:0] merged_funit;

  logic [THREADS-1:0]          ret_hit;
  logic [THREADS-1:0]          write_sel;
  logic [THREADS-1:0]          retire_set;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write merge over the bundle.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign any_new      = |new_wen;
  assign wr_lane      = newest_writer(new_wen);
  assign merged_tag   = new_tag[wr_lane];
  assign merged_funit = new_funit[wr_lane];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // retire match against both stored tags.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    ret_hit = '0;
    for (int t = 0; t < THREADS; t++)
    begin
      for (int p = 0; p < `RAT_RET_PORTS; p++)
      begin
        if (ret_wen[p] && (ret_tag[p] == tag_q[t]))
        begin
          ret_hit[t] = 1'b1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-thread entries.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar t = 0; t < THREADS; t++)
  begin : thread_gen

    assign write_sel[t]  = any_new && (cur_thread == t);
    assign retire_set[t] = (ret_hit[t] || retire_all) && (ret_thread == t);

    // reset, then new write, then retire.
    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        tag_q[t]     <= '0;
        funit_q[t]   <= FUNIT_RESET;
        retired_q[t] <= 1'b1;
      end
      else if (write_sel[t])
      begin
        tag_q[t]     <= merged_tag;
        funit_q[t]   <= merged_funit;
        retired_q[t] <= 1'b0;  // new producer in flight.
      end
      else if (retire_set[t])
      begin
        retired_q[t] <= 1'b1;
      end
    end

  end

  // entry of the registered thread.
  assign entry_tag     = tag_q[cur_thread];
  assign entry_funit   = funit_q[cur_thread];
  assign entry_retired = retired_q[cur_thread];

endmodule

/* flags_read_stage.sv */
`timescale 1ns/10ps
`include "rat_flags_settings.svh"

module flags_read_stage
  import rat_flags_pkg::*;
(
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              read_clken,
  input  logic                                              read_thread,
  input  logic [`RAT_LANES-1:0][`RAT_CODE_WIDTH-1:0]        read_code,
  input  logic [`RAT_LANES-1:0][`RAT_TAG_WIDTH-1:0]         new_tag,
  input  logic [`RAT_LANES-1:0][`RAT_FUNIT_WIDTH-1:0]       new_funit,
  input  logic [`RAT_TAG_WIDTH-1:0]                         entry_tag,
  input  logic [`RAT_FUNIT_WIDTH-1:0]                       entry_funit,
  input  logic                                              entry_retired,
  output logic                                              cur_thread,
  output logic [`RAT_LANES-1:0][`RAT_TAG_WIDTH-1:0]         read_tag,
  output logic [`RAT_LANES-1:0][`RAT_FUNIT_WIDTH-1:0]       read_funit,
  output logic [`RAT_LANES-1:0]                             read_retired
);

  // latched codes and thread.
  logic [`RAT_LANES-1:0][`RAT_CODE_WIDTH-1:0] code_q;
  logic                                       thread_q;

  // decoded source per lane.
  logic [`RAT_LANES-1:0][1:0]                 lane_src;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read code latch.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      code_q   <= '0;
      thread_q <= 1'b0;
    end
    else if (read_clken)
    begin
      code_q   <= read_code;
      thread_q <= read_thread;
    end
  end

  // same thread for table read and write.
  assign cur_thread = thread_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // source decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    for (int i = 0; i < `RAT_LANES; i++)
    begin
      lane_src[i] = code_source(code_q[i]);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-lane output select.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin : lane_mux
    logic [LANE_IDX_W-1:0] src_lane;
    for (int i = 0; i < `RAT_LANES; i++)
    begin
      src_lane        = code_q[i][LANE_IDX_W-1:0];
      read_tag[i]     = '0;   // unnamed codes read zero.
      read_funit[i]   = '0;
      read_retired[i] = 1'b0;
      case (lane_src[i])
        SRC_LANE:
        begin
          // forward from an earlier lane of this bundle.
          read_tag[i]   = new_tag[src_lane];
          read_funit[i] = new_funit[src_lane];
        end
        SRC_TABLE:
        begin
          read_tag[i]     = entry_tag;
          read_funit[i]   = entry_funit;
          read_retired[i] = entry_retired;
        end
        SRC_DONE:
        begin
          read_tag[i]     = entry_tag;
          read_funit[i]   = entry_funit;
          read_retired[i] = 1'b1;  // forced.
        end
        default:
        begin
          read_retired[i] = 1'b0;
        end
      endcase
    end
  end

endmodule

/* rat_flags.sv */
`timescale 1ns/10ps
`include "rat_flags_settings.svh"

module rat_flags (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              read_clken,
  input  logic                                              read_thread,
  input  logic                                              ret_thread,
  input  logic                                              retire_all,

  // rename bundle.
  input  logic [`RAT_LANES-1:0]                             new_wen,
  input  logic [`RAT_LANES-1:0][`RAT_TAG_WIDTH-1:0]         new_tag,
  input  logic [`RAT_LANES-1:0][`RAT_FUNIT_WIDTH-1:0]       new_funit,
  input  logic [`RAT_LANES-1:0][`RAT_CODE_WIDTH-1:0]        read_code,

  // retire ports.
  input  logic [`RAT_RET_PORTS-1:0]                         ret_wen,
  input  logic [`RAT_RET_PORTS-1:0][`RAT_TAG_WIDTH-1:0]     ret_tag,

  // per-lane read results.
  output logic [`RAT_LANES-1:0][`RAT_TAG_WIDTH-1:0]         read_tag,
  output logic [`RAT_LANES-1:0][`RAT_FUNIT_WIDTH-1:0]       read_funit,
  output logic [`RAT_LANES-1:0]                             read_retired,

  // table entry of the latched thread.
  output logic [`RAT_TAG_WIDTH-1:0]                         flags_tag,
  output logic [`RAT_FUNIT_WIDTH-1:0]                       flags_funit,
  output logic                                              flags_retired
);

  logic cur_thread;  // latched thread, read and write.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // table entries.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  flags_entry entry0 (
    .clk           (clk),
    .rst           (rst),
    .cur_thread    (cur_thread),
    .new_wen       (new_wen),
    .new_tag       (new_tag),
    .new_funit     (new_funit),
    .ret_wen       (ret_wen),
    .ret_tag       (ret_tag),
    .ret_thread    (ret_thread),
    .retire_all    (retire_all),
    .entry_tag     (flags_tag),
    .entry_funit   (flags_funit),
    .entry_retired (flags_retired)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read codes and source select.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  flags_read_stage reads0 (
    .clk           (clk),
    .rst           (rst),
    .read_clken    (read_clken),
    .read_thread   (read_thread),
    .read_code     (read_code),
    .new_tag       (new_tag),
    .new_funit     (new_funit),
    .entry_tag     (flags_tag),
    .entry_funit   (flags_funit),
    .entry_retired (flags_retired),
    .cur_thread    (cur_thread),
    .read_tag      (read_tag),
    .read_funit    (read_funit),
    .read_retired  (read_retired)
  );

endmodule

/* rat_flags_tb.sv */
`timescale 1ns/10ps
`include "rat_flags_settings.svh"

module rat_flags_tb
  import rat_flags_pkg::*;
;

  localparam int RANDOM_CYCLES = 200;
  localparam int MAX_CYCLES    = 2000;  // reset, about 40 directed and the random cycles fit.
  localparam logic [`RAT_CODE_WIDTH-1:0] CODE_FLAGS = `RAT_CODE_FLAGS;
  localparam logic [`RAT_CODE_WIDTH-1:0] CODE_DONE  = `RAT_CODE_DONE;
  localparam logic [`RAT_FUNIT_WIDTH-1:0] FUNIT_RESET = `RAT_FUNIT_RESET;

  logic clk;
  logic rst;
  logic read_clken;
  logic read_thread;
  logic ret_thread;
  logic retire_all;
  logic [`RAT_LANES-1:0]                         new_wen;
  logic [`RAT_LANES-1:0][`RAT_TAG_WIDTH-1:0]     new_tag;
  logic [`RAT_LANES-1:0][`RAT_FUNIT_WIDTH-1:0]   new_funit;
  logic [`RAT_LANES-1:0][`RAT_CODE_WIDTH-1:0]    read_code;
  logic [`RAT_RET_PORTS-1:0]                     ret_wen;
  logic [`RAT_RET_PORTS-1:0][`RAT_TAG_WIDTH-1:0] ret_tag;
  logic [`RAT_LANES-1:0][`RAT_TAG_WIDTH-1:0]     read_tag;
  logic [`RAT_LANES-1:0][`RAT_FUNIT_WIDTH-1:0]   read_funit;
  logic [`RAT_LANES-1:0]                         read_retired;
  logic [`RAT_TAG_WIDTH-1:0]                     flags_tag;
  logic [`RAT_FUNIT_WIDTH-1:0]                   flags_funit;
  logic                                          flags_retired;

  // reference model.
  logic [`RAT_TAG_WIDTH-1:0]                     m_tag   [2];
  logic [`RAT_FUNIT_WIDTH-1:0]                   m_funit [2];
  logic                                          m_ret   [2];
  logic [`RAT_LANES-1:0][`RAT_CODE_WIDTH-1:0]    m_code;
  logic                                          m_thread;

  int    errors;
  int    checks;
  int    cycles;
  string test_name;

  rat_flags dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // model and checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic compare_value(input string label, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, label, exp, act);
    end
  endtask

  task automatic verify_outputs;
    logic [`RAT_TAG_WIDTH-1:0]   e_tag;
    logic [`RAT_FUNIT_WIDTH-1:0] e_funit;
    logic                        e_ret;
    logic [1:0]                  lane_idx;
    for (int i = 0; i < `RAT_LANES; i++)
    begin
      lane_idx = m_code[i][1:0];
      e_tag    = '0;  // codes naming nothing.
      e_funit  = '0;
      e_ret    = 1'b0;
      if (m_code[i] < 4'd4)
      begin
        e_tag   = new_tag[lane_idx];
        e_funit = new_funit[lane_idx];
      end
      else if (m_code[i] == CODE_FLAGS || m_code[i] == CODE_DONE)
      begin
        e_tag   = m_tag[m_thread];
        e_funit = m_funit[m_thread];
        e_ret   = (m_code[i] == CODE_DONE) ? 1'b1 : m_ret[m_thread];
      end
      compare_value($sformatf("read_tag[%0d]", i), 32'(e_tag), 32'(read_tag[i]));
      compare_value($sformatf("read_funit[%0d]", i), 32'(e_funit), 32'(read_funit[i]));
      compare_value($sformatf("read_retired[%0d]", i), 32'(e_ret), 32'(read_retired[i]));
    end
    compare_value("flags_tag", 32'(m_tag[m_thread]), 32'(flags_tag));
    compare_value("flags_funit", 32'(m_funit[m_thread]), 32'(flags_funit));
    compare_value("flags_retired", 32'(m_ret[m_thread]), 32'(flags_retired));
  endtask

  task automatic update_model;
    logic [1:0] hit;
    int         w;
    hit = '0;
    w   = -1;
    for (int t = 0; t < 2; t++)
    begin
      for (int p = 0; p < `RAT_RET_PORTS; p++)
      begin
        if (ret_wen[p] && ret_tag[p] == m_tag[t])
        begin
          hit[t] = 1'b1;
        end
      end
      if (retire_all)
      begin
        hit[t] = 1'b1;
      end
    end
    for (int i = 0; i < `RAT_LANES; i++)
    begin
      if (new_wen[i])
      begin
        w = i;  // last one set is the newest.
      end
    end
    for (int t = 0; t < 2; t++)
    begin
      if (w >= 0 && m_thread == t[0])
      begin
        m_tag[t]   = new_tag[w];
        m_funit[t] = new_funit[w];
        m_ret[t]   = 1'b0;
      end
      else if (hit[t] && ret_thread == t[0])
      begin
        m_ret[t] = 1'b1;
      end
    end
    if (read_clken)
    begin
      m_code   = read_code;
      m_thread = read_thread;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic step_cycle;
    #40;  // just before the rising edge.
    verify_outputs();
    update_model();
    @(posedge clk);
    @(negedge clk);
    new_wen    = '0;
    ret_wen    = '0;
    retire_all = 1'b0;
    read_clken = 1'b0;
  endtask

  task automatic set_codes(input logic thread, input logic [`RAT_CODE_WIDTH-1:0] c0,
                           input logic [`RAT_CODE_WIDTH-1:0] c1,
                           input logic [`RAT_CODE_WIDTH-1:0] c2,
                           input logic [`RAT_CODE_WIDTH-1:0] c3);
    read_clken   = 1'b1;
    read_thread  = thread;
    read_code[0] = c0;
    read_code[1] = c1;
    read_code[2] = c2;
    read_code[3] = c3;
  endtask

  task automatic drive_random;
    logic [31:0] r;
    for (int i = 0; i < `RAT_LANES; i++)
    begin
      r            = $urandom;
      new_tag[i]   = r[5:0];
      new_funit[i] = r[25:16];
      read_code[i] = '0;
      case (r[30:28])
        3'd0, 3'd1, 3'd2: read_code[i][1:0] = r[7:6];
        3'd3, 3'd4:       read_code[i] = CODE_FLAGS;
        3'd5:             read_code[i] = CODE_DONE;
        default:          read_code[i] = r[11:8];
      endcase
    end
    r           = $urandom;
    new_wen     = (r[2:0] == 3'd0) ? r[7:4] : 4'b0000;  // writes now and then.
    read_clken  = r[8];
    read_thread = r[9];
    ret_thread  = r[10];
    retire_all  = (r[13:11] == 3'd0);
    ret_wen     = r[16:14];
    for (int p = 0; p < `RAT_RET_PORTS; p++)
    begin
      ret_tag[p] = r[17 + p] ? m_tag[ret_thread] : 6'(r[31:26] + p);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    void'($urandom(32'h2665));
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    test_name   = "reset";
    rst         = 1'b1;
    new_wen     = '0;
    new_tag     = '0;
    new_funit   = '0;
    read_code   = '0;
    read_clken  = 1'b0;
    read_thread = 1'b0;
    ret_wen     = '0;
    ret_tag     = '0;
    ret_thread  = 1'b0;
    retire_all  = 1'b0;
    for (int t = 0; t < 2; t++)
    begin
      m_tag[t]   = '0;
      m_funit[t] = FUNIT_RESET;
      m_ret[t]   = 1'b1;
    end
    m_code   = '0;
    m_thread = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_name = "reset_state";
    set_codes(1'b0, CODE_FLAGS, CODE_FLAGS, CODE_FLAGS, CODE_FLAGS);
    step_cycle();
    step_cycle();
    set_codes(1'b1, CODE_FLAGS, CODE_DONE, CODE_FLAGS, 4'd7);
    step_cycle();
    step_cycle();

    test_name = "new_write";
    set_codes(1'b0, CODE_FLAGS, CODE_FLAGS, CODE_DONE, CODE_FLAGS);
    step_cycle();
    new_wen   = 4'b0110;
    new_tag   = {6'h3f, 6'h2a, 6'h11, 6'h07};
    new_funit = {10'h3ff, 10'h2c3, 10'h155, 10'h001};
    step_cycle();
    step_cycle();
    set_codes(1'b1, CODE_FLAGS, CODE_FLAGS, CODE_FLAGS, CODE_FLAGS);
    step_cycle();  // other thread keeps its reset entry.
    new_wen   = 4'b1111;
    new_tag   = {6'h19, 6'h22, 6'h33, 6'h04};
    new_funit = {10'h0f0, 10'h111, 10'h222, 10'h333};
    step_cycle();
    step_cycle();

    test_name = "forwarding";
    set_codes(1'b0, 4'd0, 4'd1, 4'd2, 4'd3);
    step_cycle();
    new_tag   = {6'h01, 6'h12, 6'h23, 6'h34};
    new_funit = {10'h101, 10'h212, 10'h323, 10'h034};
    step_cycle();
    set_codes(1'b0, 4'd3, 4'd0, 4'd5, 4'd15);
    step_cycle();
    new_tag   = {6'h2e, 6'h1d, 6'h0c, 6'h3b};
    new_funit = {10'h2ee, 10'h1dd, 10'h0cc, 10'h3bb};
    step_cycle();

    test_name = "retire_match";
    set_codes(1'b0, CODE_FLAGS, CODE_DONE, CODE_FLAGS, CODE_FLAGS);
    step_cycle();
    ret_wen    = 3'b001;
    ret_tag[0] = 6'h2b;  // wrong tag.
    ret_thread = 1'b0;
    step_cycle();
    ret_wen    = 3'b010;
    ret_tag[1] = 6'h2a;
    ret_thread = 1'b1;   // wrong thread.
    step_cycle();
    new_wen      = 4'b0001;
    new_tag[0]   = 6'h2a;
    new_funit[0] = 10'h0aa;
    ret_wen      = 3'b100;
    ret_tag[2]   = 6'h2a;
    ret_thread   = 1'b0;
    step_cycle();        // write beats retire.
    step_cycle();
    ret_wen    = 3'b100;
    ret_tag[2] = 6'h2a;
    ret_thread = 1'b0;
    step_cycle();
    step_cycle();

    test_name = "retire_all";
    new_wen      = 4'b1000;
    new_tag[3]   = 6'h05;
    new_funit[3] = 10'h055;
    step_cycle();
    set_codes(1'b1, CODE_DONE, CODE_FLAGS, CODE_DONE, 4'd0);
    step_cycle();
    retire_all = 1'b1;
    ret_thread = 1'b0;
    step_cycle();
    step_cycle();
    retire_all = 1'b1;
    ret_thread = 1'b1;
    step_cycle();
    set_codes(1'b0, CODE_DONE, CODE_FLAGS, 4'd12, CODE_FLAGS);
    step_cycle();
    step_cycle();

    test_name = "random";
    for (int n = 0; n < RANDOM_CYCLES; n++)
    begin
      drive_random();
      step_cycle();
    end

    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* rat_flags.f */
+incdir+.
rat_flags_pkg.sv
flags_entry.sv
flags_read_stage.sv
rat_flags.sv
rat_flags_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f rat_flags.f \
  --top-module rat_flags_tb -o rat_flags_sim

out=$(./obj_dir/rat_flags_sim)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
